// ==== hdl/rvIsaPkg.sv ====
//--------------------
// RV32I encodings and field types
//--------------------
package rvIsaPkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [2:0]  funct3_t;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OPIMM  = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011
    } opcode_t;

    // ALU function field
    localparam funct3_t F3_ADDSUB = 3'b000;
    localparam funct3_t F3_SLL    = 3'b001;
    localparam funct3_t F3_SLT    = 3'b010;
    localparam funct3_t F3_SLTU   = 3'b011;
    localparam funct3_t F3_XOR    = 3'b100;
    localparam funct3_t F3_SR     = 3'b101;
    localparam funct3_t F3_OR     = 3'b110;
    localparam funct3_t F3_AND    = 3'b111;

    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;
    localparam funct3_t F3_BLT = 3'b100;
    localparam funct3_t F3_BGE = 3'b101;

    localparam instr_t NOP_INSTR = 32'h0000_0013;  // addi x0, x0, 0
    localparam word_t  RESET_PC  = 32'h0000_0000;

endpackage

// ==== hdl/rvPipePkg.sv ====
//--------------------
// Pipeline control types
//--------------------
package rvPipePkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } aluOp_t;

    typedef enum logic [1:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B
    } immKind_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_MEM,
        FWD_WB
    } fwdSel_t;

endpackage

// ==== hdl/decodeUnit.sv ====
`timescale 1ns/1ps
//--------------------
// Decode stage control
// Control bits, immediate and ALU operation per instruction
//--------------------
module decodeUnit
    import rvIsaPkg::*, rvPipePkg::*;
(
    input  instr_t instr,
    output logic   regWrite,
    output logic   memToReg,
    output logic   memRead,
    output logic   memWrite,
    output logic   aluSrc,
    output logic   branch,
    output aluOp_t aluOp,
    output word_t  imm
);

    immKind_t immKind;
    funct3_t  funct3;
    logic     altFn;    // funct7 bit 5, SUB and SRA

    function automatic aluOp_t aluFn(funct3_t f3, logic alt, logic isReg);
        case (f3)
            F3_ADDSUB: aluFn = (isReg && alt) ? ALU_SUB : ALU_ADD;
            F3_SLL:    aluFn = ALU_SLL;
            F3_SLT:    aluFn = ALU_SLT;
            F3_SLTU:   aluFn = ALU_SLTU;
            F3_XOR:    aluFn = ALU_XOR;
            F3_SR:     aluFn = alt ? ALU_SRA : ALU_SRL;
            F3_OR:     aluFn = ALU_OR;
            F3_AND:    aluFn = ALU_AND;
            default:   aluFn = ALU_ADD;
        endcase
    endfunction

    assign funct3 = instr[14:12];
    assign altFn  = instr[30];

    always_comb begin
        regWrite = 1'b0;
        memToReg = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        branch   = 1'b0;
        immKind  = IMM_NONE;
        aluOp    = ALU_ADD;
        case (opcode_t'(instr[6:0]))
            OPC_OP: begin
                regWrite = 1'b1;
                aluOp    = aluFn(funct3, altFn, 1'b1);
            end
            OPC_OPIMM: begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
                immKind  = IMM_I;
                aluOp    = aluFn(funct3, altFn, 1'b0);
            end
            OPC_LOAD: begin
                regWrite = 1'b1;
                memToReg = 1'b1;
                memRead  = 1'b1;
                aluSrc   = 1'b1;
                immKind  = IMM_I;
            end
            OPC_STORE: begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
                immKind  = IMM_S;
            end
            OPC_BRANCH: begin
                branch  = 1'b1;
                immKind = IMM_B;
                aluOp   = funct3[2] ? ALU_SLT : ALU_SUB;  // BLT/BGE compare by SLT
            end
            default: ;  // Unknown opcode becomes a bubble
        endcase
    end

    always_comb begin
        case (immKind)
            IMM_I:   imm = {{20{instr[31]}}, instr[31:20]};
            IMM_S:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
//--------------------
// Register file, 32 x 32 bits
// Two combinational reads, one write, x0 fixed at zero
//--------------------
module regFile
    import rvIsaPkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  regAddr_t rs1,
    input  regAddr_t rs2,
    input  regAddr_t rd,
    input  logic     writeEn,
    input  word_t    writeData,
    output word_t    rdata1,
    output word_t    rdata2
);

    word_t regs [32];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

    assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/executeUnit.sv ====
`timescale 1ns/1ps
//--------------------
// Execute stage
// Operand forwarding, ALU and branch resolution
//--------------------
module executeUnit
    import rvIsaPkg::*, rvPipePkg::*;
(
    input  word_t   pc,
    input  word_t   rdata1,
    input  word_t   rdata2,
    input  word_t   imm,
    input  logic    aluSrc,
    input  logic    branch,
    input  funct3_t funct3,
    input  aluOp_t  aluOp,
    input  fwdSel_t fwdA,
    input  fwdSel_t fwdB,
    input  word_t   memResult,
    input  word_t   wbResult,
    output word_t   aluResult,
    output word_t   storeData,
    output word_t   branchTarget,
    output logic    branchTaken
);

    word_t opA;
    word_t opB;
    word_t regB;     // Forwarded rs2, before the immediate mux
    logic  zero;
    logic  cond;

    function automatic word_t pickFwd(fwdSel_t sel, word_t regVal, word_t memVal,
                                      word_t wbVal);
        case (sel)
            FWD_MEM: pickFwd = memVal;
            FWD_WB:  pickFwd = wbVal;
            default: pickFwd = regVal;
        endcase
    endfunction

    assign opA       = pickFwd(fwdA, rdata1, memResult, wbResult);
    assign regB      = pickFwd(fwdB, rdata2, memResult, wbResult);
    assign opB       = aluSrc ? imm : regB;
    assign storeData = regB;

    always_comb begin
        case (aluOp)
            ALU_ADD:  aluResult = opA + opB;
            ALU_SUB:  aluResult = opA - opB;
            ALU_AND:  aluResult = opA & opB;
            ALU_OR:   aluResult = opA | opB;
            ALU_XOR:  aluResult = opA ^ opB;
            ALU_SLL:  aluResult = opA << opB[4:0];
            ALU_SRL:  aluResult = opA >> opB[4:0];
            ALU_SRA:  aluResult = $signed(opA) >>> opB[4:0];
            ALU_SLT:  aluResult = {31'b0, ($signed(opA) < $signed(opB))};
            ALU_SLTU: aluResult = {31'b0, (opA < opB)};
            default:  aluResult = '0;
        endcase
    end

    assign zero = (aluResult == '0);

    // SUB result for BEQ/BNE, SLT bit for BLT/BGE
    always_comb begin
        case (funct3)
            F3_BEQ:  cond = zero;
            F3_BNE:  cond = !zero;
            F3_BLT:  cond = aluResult[0];
            F3_BGE:  cond = !aluResult[0];
            default: cond = 1'b0;
        endcase
    end

    assign branchTaken  = branch && cond;
    assign branchTarget = pc + imm;

endmodule

// ==== hdl/hazardUnit.sv ====
`timescale 1ns/1ps
//--------------------
// Hazard control
// Forward selects, load-use stall, branch flush
//--------------------
module hazardUnit
    import rvIsaPkg::*, rvPipePkg::*;
(
    input  regAddr_t decRs1,
    input  regAddr_t decRs2,
    input  regAddr_t exRs1,
    input  regAddr_t exRs2,
    input  regAddr_t exRd,
    input  regAddr_t memRd,
    input  regAddr_t wbRd,
    input  logic     exMemRead,
    input  logic     memRegWrite,
    input  logic     wbRegWrite,
    input  logic     branchTaken,
    output fwdSel_t  fwdA,
    output fwdSel_t  fwdB,
    output logic     stall,
    output logic     flush
);

    logic memFwdOk;
    logic wbFwdOk;

    assign memFwdOk = memRegWrite && (memRd != '0);
    assign wbFwdOk  = wbRegWrite && (wbRd != '0);

    // Memory stage is younger, so it wins
    always_comb begin
        fwdA = FWD_REG;
        fwdB = FWD_REG;
        if (memFwdOk && (memRd == exRs1)) fwdA = FWD_MEM;
        else if (wbFwdOk && (wbRd == exRs1)) fwdA = FWD_WB;
        if (memFwdOk && (memRd == exRs2)) fwdB = FWD_MEM;
        else if (wbFwdOk && (wbRd == exRs2)) fwdB = FWD_WB;
    end

    assign stall = exMemRead && (exRd != '0) && ((exRd == decRs1) || (exRd == decRs2));
    assign flush = branchTaken;    // Kills IF/ID and ID/EX

endmodule

// ==== hdl/dataMemory.sv ====
`timescale 1ns/1ps
//--------------------
// Data RAM, word addressed
//--------------------
module dataMemory
    import rvIsaPkg::*;
#(
    parameter int DMEM_ADDR_W = 10
)
(
    input  logic  clk,
    input  logic  writeEn,
    input  logic  readEn,
    input  word_t addr,
    input  word_t writeData,
    output word_t readData
);

    localparam int DEPTH = 1 << DMEM_ADDR_W;

    word_t                  mem [DEPTH];
    logic [DMEM_ADDR_W-1:0] wordAddr;

    assign wordAddr = addr[DMEM_ADDR_W+1:2];

    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always @(posedge clk) begin
        if (writeEn) begin
            mem[wordAddr] <= writeData;
        end
    end

    assign readData = readEn ? mem[wordAddr] : '0;

endmodule

// ==== hdl/rvCore.sv ====
`timescale 1ns/1ps
//--------------------
// RV32I five-stage pipeline core
// PC, pipeline registers, write-back and observation port
//--------------------
module rvCore
    import rvIsaPkg::*, rvPipePkg::*;
#(
    parameter int DMEM_ADDR_W = 10
)
(
    input  logic     clk,
    input  logic     reset,
    input  instr_t   instr,
    output word_t    fetchAddr,
    output logic     wbValid,
    output regAddr_t wbRd,
    output word_t    wbData
);

    word_t    pc;
    word_t    ifIdPc;
    instr_t   ifIdInstr;

    logic     decRegWrite, decMemToReg, decMemRead, decMemWrite, decAluSrc, decBranch;
    aluOp_t   decAluOp;
    word_t    decImm, rdata1, rdata2, decData1, decData2;
    regAddr_t decRs1, decRs2, decRd;

    logic     idExRegWrite, idExMemToReg, idExMemRead, idExMemWrite, idExAluSrc;
    logic     idExBranch;
    aluOp_t   idExAluOp;
    funct3_t  idExFunct3;
    regAddr_t idExRs1, idExRs2, idExRd;
    word_t    idExPc, idExData1, idExData2, idExImm;

    fwdSel_t  fwdA, fwdB;
    word_t    aluResult, storeData, branchTarget;
    logic     branchTaken, stall, flush;

    logic     exMemRegWrite, exMemMemToReg, exMemMemRead, exMemMemWrite;
    regAddr_t exMemRd;
    word_t    exMemAluResult, exMemStoreData, memData;

    logic     memWbRegWrite, memWbMemToReg;
    regAddr_t memWbRd;
    word_t    memWbAluResult, memWbMemData;

    assign fetchAddr = pc;

    // Flush beats stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= branchTarget;
        end else if (!stall) begin
            pc <= pc + 32'd4;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ifIdInstr <= NOP_INSTR;
        end else if (flush) begin
            ifIdInstr <= NOP_INSTR;
        end else if (!stall) begin
            ifIdInstr <= instr;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) ifIdPc <= pc;   // Own address, for the branch target
    end

    assign decRs1 = ifIdInstr[19:15];
    assign decRs2 = ifIdInstr[24:20];
    assign decRd  = ifIdInstr[11:7];

    decodeUnit decode0 (
        .instr(ifIdInstr), .regWrite(decRegWrite), .memToReg(decMemToReg),
        .memRead(decMemRead), .memWrite(decMemWrite), .aluSrc(decAluSrc),
        .branch(decBranch), .aluOp(decAluOp), .imm(decImm)
    );

    regFile regFile0 (
        .clk(clk), .reset(reset), .rs1(decRs1), .rs2(decRs2), .rd(memWbRd),
        .writeEn(memWbRegWrite), .writeData(wbData), .rdata1(rdata1), .rdata2(rdata2)
    );

    // Value retiring this cycle is not in the register file yet
    assign decData1 = (wbValid && (memWbRd == decRs1)) ? wbData : rdata1;
    assign decData2 = (wbValid && (memWbRd == decRs2)) ? wbData : rdata2;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            idExRegWrite <= 1'b0;
            idExMemToReg <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExAluSrc   <= 1'b0;
            idExBranch   <= 1'b0;
            idExAluOp    <= ALU_ADD;
        end else if (flush || stall) begin  // Bubble
            idExRegWrite <= 1'b0;
            idExMemToReg <= 1'b0;
            idExMemRead  <= 1'b0;
            idExMemWrite <= 1'b0;
            idExAluSrc   <= 1'b0;
            idExBranch   <= 1'b0;
            idExAluOp    <= ALU_ADD;
        end else begin
            idExRegWrite <= decRegWrite;
            idExMemToReg <= decMemToReg;
            idExMemRead  <= decMemRead;
            idExMemWrite <= decMemWrite;
            idExAluSrc   <= decAluSrc;
            idExBranch   <= decBranch;
            idExAluOp    <= decAluOp;
        end
    end

    always_ff @(posedge clk) begin
        idExPc     <= ifIdPc;
        idExData1  <= decData1;
        idExData2  <= decData2;
        idExImm    <= decImm;
        idExRs1    <= decRs1;
        idExRs2    <= decRs2;
        idExRd     <= decRd;
        idExFunct3 <= ifIdInstr[14:12];
    end

    hazardUnit hazard0 (
        .decRs1(decRs1), .decRs2(decRs2), .exRs1(idExRs1), .exRs2(idExRs2),
        .exRd(idExRd), .memRd(exMemRd), .wbRd(memWbRd), .exMemRead(idExMemRead),
        .memRegWrite(exMemRegWrite), .wbRegWrite(memWbRegWrite),
        .branchTaken(branchTaken), .fwdA(fwdA), .fwdB(fwdB), .stall(stall), .flush(flush)
    );

    executeUnit execute0 (
        .pc(idExPc), .rdata1(idExData1), .rdata2(idExData2), .imm(idExImm),
        .aluSrc(idExAluSrc), .branch(idExBranch), .funct3(idExFunct3), .aluOp(idExAluOp),
        .fwdA(fwdA), .fwdB(fwdB), .memResult(exMemAluResult), .wbResult(wbData),
        .aluResult(aluResult), .storeData(storeData), .branchTarget(branchTarget),
        .branchTaken(branchTaken)
    );

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            exMemRegWrite <= 1'b0;
            exMemMemToReg <= 1'b0;
            exMemMemRead  <= 1'b0;
            exMemMemWrite <= 1'b0;
            memWbRegWrite <= 1'b0;
            memWbMemToReg <= 1'b0;
        end else begin
            exMemRegWrite <= idExRegWrite;
            exMemMemToReg <= idExMemToReg;
            exMemMemRead  <= idExMemRead;
            exMemMemWrite <= idExMemWrite;
            memWbRegWrite <= exMemRegWrite;
            memWbMemToReg <= exMemMemToReg;
        end
    end

    always_ff @(posedge clk) begin
        exMemRd        <= idExRd;
        exMemAluResult <= aluResult;
        exMemStoreData <= storeData;
        memWbRd        <= exMemRd;
        memWbAluResult <= exMemAluResult;
        memWbMemData   <= memData;
    end

    dataMemory #(
        .DMEM_ADDR_W(DMEM_ADDR_W)
    ) dmem0 (
        .clk(clk), .writeEn(exMemMemWrite), .readEn(exMemMemRead),
        .addr(exMemAluResult), .writeData(exMemStoreData), .readData(memData)
    );

    assign wbData  = memWbMemToReg ? memWbMemData : memWbAluResult;
    assign wbValid = memWbRegWrite && (memWbRd != '0);   // x0 writes stay hidden
    assign wbRd    = memWbRd;

endmodule

// ==== test/rvCoreChecker.sv ====
`timescale 1ns/1ps
//--------------------
// Port assertions for rvCore
//--------------------
module rvCoreChecker
    import rvIsaPkg::*;
(
    input logic     clk,
    input logic     reset,
    input word_t    fetchAddr,
    input logic     wbValid,
    input regAddr_t wbRd,
    input word_t    wbData
);

    // Retiring register and value fully defined
    wbKnown: assert property (
        @(posedge clk) disable iff (reset) wbValid |-> !$isunknown({wbRd, wbData})
    ) else $error("write-back register or data unknown");

    fetchAligned: assert property (
        @(posedge clk) disable iff (reset) fetchAddr[1:0] == 2'b00
    ) else $error("fetch address 0x%08h not word aligned", fetchAddr);

    // Pipeline is empty right after reset
    quietAfterReset: assert property (
        @(posedge clk) $fell(reset) |-> !wbValid
    ) else $error("write-back in the first cycle after reset");

endmodule

bind rvCore rvCoreChecker checker0 (
    .clk(clk), .reset(reset), .fetchAddr(fetchAddr), .wbValid(wbValid), .wbRd(wbRd),
    .wbData(wbData)
);

// ==== test/rvCoreTb.sv ====
`timescale 1ns/1ps
//--------------------
// rvCore testbench
// Program table, instruction responder, write-back checks
//--------------------
module rvCoreTb
    import rvIsaPkg::*;
();

    localparam int MAX_STEPS    = 64;
    localparam int WB_TIMEOUT   = 50;
    localparam int QUIET_CYCLES = 20;

    logic     clk;
    logic     reset;
    instr_t   instr;
    word_t    fetchAddr;
    logic     wbValid;
    regAddr_t wbRd;
    word_t    wbData;

    // One entry per instruction, in program order
    instr_t   progMem [MAX_STEPS];
    logic     hasWb [MAX_STEPS];
    regAddr_t expRd [MAX_STEPS];
    word_t    expVal [MAX_STEPS];
    string    testName [MAX_STEPS];
    int       stepCount = 0;

    rvCore #(
        .DMEM_ADDR_W(10)
    ) dut0 (
        .clk(clk), .reset(reset), .instr(instr), .fetchAddr(fetchAddr),
        .wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic instr_t rType(input logic [6:0] f7, input regAddr_t rs2,
                                     input regAddr_t rs1, input funct3_t f3,
                                     input regAddr_t rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t iType(input logic [11:0] imm, input regAddr_t rs1,
                                     input funct3_t f3, input regAddr_t rd,
                                     input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic instr_t sType(input logic [11:0] imm, input regAddr_t rs2,
                                     input regAddr_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};  // SW
    endfunction

    function automatic instr_t bType(input logic [12:0] imm, input regAddr_t rs2,
                                     input regAddr_t rs1, input funct3_t f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    task automatic addStep(input string name, input instr_t word, input regAddr_t rd,
                           input word_t value);
        progMem[stepCount]  = word;
        hasWb[stepCount]    = 1'b1;
        expRd[stepCount]    = rd;
        expVal[stepCount]   = value;
        testName[stepCount] = name;
        stepCount++;
    endtask

    // Stores, branches, x0 writes and flushed instructions
    task automatic addSilentStep(input string name, input instr_t word);
        progMem[stepCount]  = word;
        hasWb[stepCount]    = 1'b0;
        expRd[stepCount]    = '0;
        expVal[stepCount]   = '0;
        testName[stepCount] = name;
        stepCount++;
    endtask

    task automatic buildProgram();
        // ALU chain with back-to-back dependencies
        addStep("addi_x1", iType(12'h005, 5'd0, F3_ADDSUB, 5'd1, OPC_OPIMM), 5'd1, 32'h5);
        addStep("addi_x2", iType(12'h007, 5'd1, F3_ADDSUB, 5'd2, OPC_OPIMM), 5'd2, 32'hC);
        addStep("add_x3", rType(7'h00, 5'd2, 5'd1, F3_ADDSUB, 5'd3), 5'd3, 32'h11);
        addStep("sub_x4", rType(7'h20, 5'd3, 5'd1, F3_ADDSUB, 5'd4), 5'd4, 32'hFFFF_FFF4);
        addStep("and_x5", rType(7'h00, 5'd3, 5'd4, F3_AND, 5'd5), 5'd5, 32'h10);
        addStep("or_x6", rType(7'h00, 5'd1, 5'd5, F3_OR, 5'd6), 5'd6, 32'h15);
        addStep("xor_x7", rType(7'h00, 5'd4, 5'd6, F3_XOR, 5'd7), 5'd7, 32'hFFFF_FFE1);
        addStep("slli_x8", iType(12'h004, 5'd6, F3_SLL, 5'd8, OPC_OPIMM), 5'd8, 32'h150);
        addStep("srai_x9", iType(12'h402, 5'd7, F3_SR, 5'd9, OPC_OPIMM), 5'd9, 32'hFFFF_FFF8);
        addStep("srli_x10", iType(12'h01C, 5'd7, F3_SR, 5'd10, OPC_OPIMM), 5'd10, 32'hF);
        addStep("slt_x11", rType(7'h00, 5'd1, 5'd9, F3_SLT, 5'd11), 5'd11, 32'h1);
        addStep("sltu_x12", rType(7'h00, 5'd1, 5'd9, F3_SLTU, 5'd12), 5'd12, 32'h0);
        addStep("sll_x13", rType(7'h00, 5'd10, 5'd1, F3_SLL, 5'd13), 5'd13, 32'h2_8000);
        addStep("srl_x14", rType(7'h00, 5'd1, 5'd7, F3_SR, 5'd14), 5'd14, 32'h07FF_FFFF);
        addStep("sra_x15", rType(7'h20, 5'd1, 5'd4, F3_SR, 5'd15), 5'd15, 32'hFFFF_FFFF);
        addStep("slti_x16", iType(12'hFF5, 5'd4, F3_SLT, 5'd16, OPC_OPIMM), 5'd16, 32'h1);
        addStep("sltiu_x17", iType(12'hFFF, 5'd1, F3_SLTU, 5'd17, OPC_OPIMM), 5'd17, 32'h1);
        addStep("andi_x18", iType(12'h0FF, 5'd7, F3_AND, 5'd18, OPC_OPIMM), 5'd18, 32'hE1);
        addStep("ori_x19", iType(12'h007, 5'd5, F3_OR, 5'd19, OPC_OPIMM), 5'd19, 32'h17);
        addStep("xori_x20", iType(12'hFFF, 5'd6, F3_XOR, 5'd20, OPC_OPIMM), 5'd20,
                32'hFFFF_FFEA);
        // Store, load, then immediate use of the loaded value
        addStep("addi_x21", iType(12'h040, 5'd0, F3_ADDSUB, 5'd21, OPC_OPIMM), 5'd21, 32'h40);
        addSilentStep("sw_x13", sType(12'h004, 5'd13, 5'd21));
        addStep("lw_x22", iType(12'h004, 5'd21, 3'b010, 5'd22, OPC_LOAD), 5'd22, 32'h2_8000);
        addStep("add_x23", rType(7'h00, 5'd1, 5'd22, F3_ADDSUB, 5'd23), 5'd23, 32'h2_8005);
        // x0 stays zero
        addSilentStep("addi_x0", iType(12'd99, 5'd0, F3_ADDSUB, 5'd0, OPC_OPIMM));
        addSilentStep("add_x0", rType(7'h00, 5'd2, 5'd1, F3_ADDSUB, 5'd0));
        addStep("add_x24", rType(7'h00, 5'd6, 5'd0, F3_ADDSUB, 5'd24), 5'd24, 32'h15);
        // Taken branches, two instructions each are flushed
        addSilentStep("beq_taken", bType(13'd12, 5'd1, 5'd1, F3_BEQ));
        addSilentStep("beq_skip_a", iType(12'h001, 5'd0, F3_ADDSUB, 5'd25, OPC_OPIMM));
        addSilentStep("beq_skip_b", iType(12'h002, 5'd0, F3_ADDSUB, 5'd25, OPC_OPIMM));
        addStep("addi_x26", iType(12'h003, 5'd0, F3_ADDSUB, 5'd26, OPC_OPIMM), 5'd26, 32'h3);
        addSilentStep("blt_taken", bType(13'd12, 5'd1, 5'd4, F3_BLT));
        addSilentStep("blt_skip_a", iType(12'h004, 5'd0, F3_ADDSUB, 5'd27, OPC_OPIMM));
        addSilentStep("blt_skip_b", iType(12'h005, 5'd0, F3_ADDSUB, 5'd27, OPC_OPIMM));
        addStep("addi_x28", iType(12'h006, 5'd26, F3_ADDSUB, 5'd28, OPC_OPIMM), 5'd28, 32'h9);
        // Not-taken branches fall through
        addSilentStep("bne_fall", bType(13'd8, 5'd1, 5'd1, F3_BNE));
        addStep("addi_x29", iType(12'h007, 5'd0, F3_ADDSUB, 5'd29, OPC_OPIMM), 5'd29, 32'h7);
        addSilentStep("bge_fall", bType(13'd8, 5'd1, 5'd4, F3_BGE));
        addStep("addi_x30", iType(12'h001, 5'd29, F3_ADDSUB, 5'd30, OPC_OPIMM), 5'd30, 32'h8);
        addStep("add_x31", rType(7'h00, 5'd28, 5'd30, F3_ADDSUB, 5'd31), 5'd31, 32'h11);
    endtask

    // Past the end of the table the core sees NOPs
    function automatic instr_t fetchWord(input word_t addr);
        word_t idx;
        idx = addr >> 2;
        if ($isunknown(addr) || (idx >= word_t'(stepCount))) begin
            return NOP_INSTR;
        end
        return progMem[idx[5:0]];
    endfunction

    task automatic applyInstr();
        forever begin
            @(posedge clk);
            #1;
            instr = fetchWord(fetchAddr);
        end
    endtask

    initial applyInstr();

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic checkEq(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abortRun($sformatf("** Error %s: expected 0x%08h, actual 0x%08h",
                               name, expected, actual));
        end
    endtask

    task automatic waitWb(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!wbValid) begin
            if (cycles >= WB_TIMEOUT) begin
                abortRun($sformatf("No write-back for %s within %0d cycles", name,
                                   WB_TIMEOUT));
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
    endtask

    task automatic checkQuiet();
        for (int cycles = 0; cycles < QUIET_CYCLES; cycles++) begin
            @(negedge clk);
            if (wbValid) begin
                abortRun($sformatf("Unexpected write-back to x%0d after the last result",
                                   wbRd));
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        instr = NOP_INSTR;
        buildProgram();
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        checkEq("reset_fetch_addr", RESET_PC, fetchAddr);
        for (int idx = 0; idx < stepCount; idx++) begin
            if (hasWb[idx]) begin
                waitWb(testName[idx]);
                checkEq({testName[idx], "_rd"}, {27'b0, expRd[idx]}, {27'b0, wbRd});
                checkEq({testName[idx], "_data"}, expVal[idx], wbData);
            end
        end
        checkQuiet();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== project.f ====
hdl/rvIsaPkg.sv
hdl/rvPipePkg.sv
hdl/decodeUnit.sv
hdl/regFile.sv
hdl/executeUnit.sv
hdl/hazardUnit.sv
hdl/dataMemory.sv
hdl/rvCore.sv
test/rvCoreChecker.sv
test/rvCoreTb.sv

// ==== Makefile ====
# Verilator build and run for the rvCore testbench

VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= TEST PASS

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
